// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath width, one word
`define DATA_WIDTH 32

// instruction field positions
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define SHAMT_MSB  10 // shift amount, R-type only
`define SHAMT_LSB  6
`define FUNCT_MSB  5
`define FUNCT_LSB  0
`define IMM_MSB    15 // 16-bit immediate
`define IMM_LSB    0

// opcodes
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_SUBI  6'b001110 // not a real MIPS opcode, local extension
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// R-type function codes
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_JR    6'b001000
`define FN_MFHI  6'b010000
`define FN_MFLO  6'b010010
`define FN_MULT  6'b011000
`define FN_MUL   6'b011001 // sits where multu would be
`define FN_DIV   6'b011010
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010

`endif

// File: mips_pkg.sv
package mips_pkg;

	// alu operation class from the main decoder
	typedef enum logic [2:0] {
		add_op   = 3'b000, // addi, lw, sw
		rtype_op = 3'b001, // look at funct
		and_op   = 3'b010, // andi
		or_op    = 3'b011, // ori
		sub_op   = 3'b100, // subi, beq
		bne_op   = 3'b101,
		slt_op   = 3'b110, // slti
		nop_op   = 3'b111  // j, jal, unknown
	} alu_op_t;

	// alu control code, one per datapath function
	typedef enum logic [3:0] {
		ctrl_add    = 4'b0000,
		ctrl_sll    = 4'b0010,
		ctrl_srl    = 4'b0011,
		ctrl_sub    = 4'b0100,
		ctrl_slt    = 4'b0101,
		ctrl_sub_ne = 4'b0110, // bne, zero flag inverted
		ctrl_mflo   = 4'b0111,
		ctrl_and    = 4'b1000,
		ctrl_mul    = 4'b1001,
		ctrl_or     = 4'b1010,
		ctrl_div    = 4'b1011,
		ctrl_nor    = 4'b1100,
		ctrl_mult   = 4'b1101,
		ctrl_mfhi   = 4'b1110,
		ctrl_nop    = 4'b1111
	} alu_ctrl_t;

endpackage

// File: main_control.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module main_control (
	input  logic [5:0]        opcode,
	output mips_pkg::alu_op_t alu_op,
	output logic              alu_src_imm, // operand b from immediate
	output logic              imm_zero_ext // zero- instead of sign-extend
);

	import mips_pkg::*;

	always_comb
	begin
		// register-register, sign extension unless told otherwise
		alu_op       = nop_op;
		alu_src_imm  = 1'b0;
		imm_zero_ext = 1'b0;
		case (opcode)
			`OP_RTYPE:
			begin
				alu_op = rtype_op; // funct decides
			end
			`OP_ADDI, `OP_LW, `OP_SW:
			begin
				alu_op      = add_op;
				alu_src_imm = 1'b1; // address / sum with signed offset
			end
			`OP_SUBI:
			begin
				alu_op      = sub_op;
				alu_src_imm = 1'b1;
			end
			`OP_BEQ:
			begin
				alu_op = sub_op; // compare rs and rt
			end
			`OP_BNE:
			begin
				alu_op = bne_op;
			end
			`OP_SLTI:
			begin
				alu_op      = slt_op;
				alu_src_imm = 1'b1;
			end
			`OP_ANDI:
			begin
				alu_op       = and_op;
				alu_src_imm  = 1'b1;
				imm_zero_ext = 1'b1; // logical immediates zero-extend
			end
			`OP_ORI:
			begin
				alu_op       = or_op;
				alu_src_imm  = 1'b1;
				imm_zero_ext = 1'b1;
			end
			`OP_J, `OP_JAL: alu_op = nop_op; // target math lives elsewhere
			default:        alu_op = nop_op; // unknown opcode
		endcase
	end

endmodule

// File: alu_control.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module alu_control (
	input  logic [5:0]          funct,
	input  mips_pkg::alu_op_t   alu_op,
	output mips_pkg::alu_ctrl_t alu_ctrl
);

	import mips_pkg::*;

	// funct only matters for R-type
	always_comb
	begin
		case (alu_op)
			add_op: alu_ctrl = ctrl_add;    // addi, lw, sw
			sub_op: alu_ctrl = ctrl_sub;    // subi, beq
			bne_op: alu_ctrl = ctrl_sub_ne; // own class now
			slt_op: alu_ctrl = ctrl_slt;    // slti
			and_op: alu_ctrl = ctrl_and;
			or_op:  alu_ctrl = ctrl_or;
			nop_op: alu_ctrl = ctrl_nop;    // j, jal
			rtype_op:
			begin
				case (funct)
					`FN_ADD:  alu_ctrl = ctrl_add;
					`FN_SUB:  alu_ctrl = ctrl_sub;
					`FN_AND:  alu_ctrl = ctrl_and;
					`FN_OR:   alu_ctrl = ctrl_or;
					`FN_NOR:  alu_ctrl = ctrl_nor;
					`FN_SLT:  alu_ctrl = ctrl_slt;
					`FN_SLL:  alu_ctrl = ctrl_sll;
					`FN_SRL:  alu_ctrl = ctrl_srl;
					`FN_JR:   alu_ctrl = ctrl_nop; // jump, nothing to compute
					`FN_MULT: alu_ctrl = ctrl_mult;
					`FN_MUL:  alu_ctrl = ctrl_mul;
					`FN_DIV:  alu_ctrl = ctrl_div;
					`FN_MFHI: alu_ctrl = ctrl_mfhi;
					`FN_MFLO: alu_ctrl = ctrl_mflo;
					default:  alu_ctrl = ctrl_nop; // unknown funct
				endcase
			end
			default: alu_ctrl = ctrl_nop;
		endcase
	end

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module alu (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      en,   // instruction valid, gates hi/lo
	input  mips_pkg::alu_ctrl_t       alu_ctrl,
	input  logic [`DATA_WIDTH-1:0]    a,
	input  logic [`DATA_WIDTH-1:0]    b,
	input  logic [4:0]                shamt,
	output logic [`DATA_WIDTH-1:0]    result,
	output logic                      zero
);

	import mips_pkg::*;

	logic [`DATA_WIDTH-1:0]          hi;
	logic [`DATA_WIDTH-1:0]          lo;
	logic signed [2*`DATA_WIDTH-1:0] prod;   // full signed product
	logic                            div_by_zero;
	logic [`DATA_WIDTH-1:0]          div_b;  // never zero, keeps divider defined
	logic signed [`DATA_WIDTH-1:0]   quot;
	logic signed [`DATA_WIDTH-1:0]   rem;

	assign prod        = $signed(a) * $signed(b); // operands widen to 64 bits
	assign div_by_zero = (b == '0);
	assign div_b       = div_by_zero ? `DATA_WIDTH'(1) : b;
	assign quot        = $signed(a) / $signed(div_b);
	assign rem         = $signed(a) % $signed(div_b);

	always_comb
	begin
		case (alu_ctrl)
			ctrl_add:    result = a + b; // wraps
			ctrl_sub:    result = a - b;
			ctrl_sub_ne: result = a - b;
			ctrl_and:    result = a & b;
			ctrl_or:     result = a | b;
			ctrl_nor:    result = ~(a | b);
			ctrl_slt:    result = {{(`DATA_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};
			ctrl_sll:    result = b << shamt;
			ctrl_srl:    result = b >> shamt; // logical
			ctrl_mul:    result = prod[`DATA_WIDTH-1:0]; // low word straight out
			ctrl_mult:   result = '0;  // only hi/lo change
			ctrl_div:    result = '0;
			ctrl_mfhi:   result = hi;
			ctrl_mflo:   result = lo;
			default:     result = '0;  // nop
		endcase
	end

	// bne reports "taken" on the zero flag
	assign zero = (alu_ctrl == ctrl_sub_ne) ? (a != b) : (result == '0);

	// hi/lo pair, written only by accepted mult, mul, div
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (en)
		begin
			case (alu_ctrl)
				ctrl_mult, ctrl_mul:
				begin
					hi <= prod[2*`DATA_WIDTH-1:`DATA_WIDTH];
					lo <= prod[`DATA_WIDTH-1:0];
				end
				ctrl_div:
				begin
					hi <= div_by_zero ? a : rem;  // remainder
					lo <= div_by_zero ? '1 : quot; // quotient, all ones on /0
				end
				default:
				begin
					hi <= hi; // everything else leaves them alone
					lo <= lo;
				end
			endcase
		end
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module execute_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [31:0]            instr,
	input  logic [`DATA_WIDTH-1:0] rs_data,
	input  logic [`DATA_WIDTH-1:0] rt_data,
	input  logic                   in_valid,  // one-cycle strobe
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   zero,
	output logic                   out_valid  // one cycle after in_valid
);

	import mips_pkg::*;

	logic [5:0]             opcode;
	logic [5:0]             funct;
	logic [4:0]             shamt;
	logic [15:0]            imm;
	logic [`DATA_WIDTH-1:0] imm_ext;
	logic [`DATA_WIDTH-1:0] op_b;
	alu_op_t                alu_op;
	alu_ctrl_t              alu_ctrl;
	logic                   alu_src_imm;
	logic                   imm_zero_ext;
	logic [`DATA_WIDTH-1:0] alu_result;
	logic                   alu_zero;

	// field split
	assign opcode = instr[`OPCODE_MSB:`OPCODE_LSB];
	assign funct  = instr[`FUNCT_MSB:`FUNCT_LSB];
	assign shamt  = instr[`SHAMT_MSB:`SHAMT_LSB];
	assign imm    = instr[`IMM_MSB:`IMM_LSB];

	assign imm_ext = imm_zero_ext ? {{(`DATA_WIDTH-16){1'b0}}, imm}
	                              : {{(`DATA_WIDTH-16){imm[15]}}, imm};
	assign op_b    = alu_src_imm ? imm_ext : rt_data; // operand b mux

	main_control u_main_control (
		.opcode       (opcode),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.imm_zero_ext (imm_zero_ext)
	);

	alu_control u_alu_control (
		.funct    (funct),
		.alu_op   (alu_op),
		.alu_ctrl (alu_ctrl)
	);

	alu u_alu (
		.clk      (clk),
		.rst      (rst),
		.en       (in_valid), // hi/lo only move on real instructions
		.alu_ctrl (alu_ctrl),
		.a        (rs_data),
		.b        (op_b),
		.shamt    (shamt),
		.result   (alu_result),
		.zero     (alu_zero)
	);

	// output stage, one result in flight
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			result    <= '0;
			zero      <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
			begin
				result <= alu_result; // hold last value otherwise
				zero   <= alu_zero;
			end
		end
	end

endmodule

// File: execute_checker.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module execute_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  logic                   out_valid,
	input  logic [`DATA_WIDTH-1:0] result,
	input  logic                   zero,
	input  logic [`DATA_WIDTH-1:0] exp_result,
	input  logic                   exp_zero,
	input  int                     exp_idx,
	output int                     pass_count,
	output int                     fail_count,
	output int                     done_count // tests finished, good or bad
);

	logic [`DATA_WIDTH-1:0] res_q [$]; // expected values in issue order
	logic                   zero_q [$];
	int                     idx_q [$];
	logic [`DATA_WIDTH-1:0] want_res;
	logic                   want_zero;
	int                     want_idx;

	// mid-cycle sampling, everything settled
	always @(negedge clk)
	begin
		if (rst)
		begin
			res_q.delete();
			zero_q.delete();
			idx_q.delete();
			pass_count = 0;
			fail_count = 0;
			done_count = 0;
		end
		else
		begin
			if (out_valid && res_q.size() == 0)
			begin
				$display("error at %0t: out_valid with no instruction in flight", $time);
				fail_count++;
			end
			else if (res_q.size() != 0)
			begin
				want_res  = res_q.pop_front(); // issued one cycle ago
				want_zero = zero_q.pop_front();
				want_idx  = idx_q.pop_front();
				if (!out_valid)
				begin
					$display("test %0d failed at %0t: no out_valid one cycle after in_valid",
						want_idx, $time);
					fail_count++;
				end
				else if (result !== want_res || zero !== want_zero)
				begin
					$display("mismatch at %0t: test %0d result %h expected %h, zero %b expected %b",
						$time, want_idx, result, want_res, zero, want_zero);
					fail_count++;
				end
				else
				begin
					$display("test %0d ok at %0t: result %h zero %b", want_idx, $time, result, zero);
					pass_count++;
				end
				done_count++;
			end
			if (in_valid)
			begin
				res_q.push_back(exp_result);
				zero_q.push_back(exp_zero);
				idx_q.push_back(exp_idx);
			end
		end
	end

endmodule

// File: execute_assert.sv
`timescale 1ns/1ps

module execute_assert (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid
);

	// quiet in reset and right after release
	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high while in reset");
	a_release_quiet: assert property (@(posedge clk) $fell(rst) |=> !out_valid)
		else $error("out_valid high in the first cycle after reset");

	// exactly one cycle of latency
	a_follow: assert property (@(posedge clk) disable iff (rst) in_valid |=> out_valid)
		else $error("out_valid missing one cycle after in_valid");
	a_no_orphan: assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid))
		else $error("out_valid without in_valid in the cycle before");

endmodule

bind execute_stage execute_assert u_execute_assert (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid)
);

// File: tb_execute_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_execute_stage;

	logic                   clk;
	logic                   rst;
	logic [31:0]            instr;
	logic [`DATA_WIDTH-1:0] rs_data;
	logic [`DATA_WIDTH-1:0] rt_data;
	logic                   in_valid;
	logic [`DATA_WIDTH-1:0] result;
	logic                   zero;
	logic                   out_valid;
	logic [`DATA_WIDTH-1:0] exp_result; // travels with the instruction
	logic                   exp_zero;
	int                     exp_idx;
	int                     pass_count;
	int                     fail_count;
	int                     done_count;

	// stimulus table with one row per instruction
	logic [31:0]            tab_instr [0:63];
	logic [`DATA_WIDTH-1:0] tab_rs    [0:63];
	logic [`DATA_WIDTH-1:0] tab_rt    [0:63];
	logic [`DATA_WIDTH-1:0] tab_res   [0:63];
	logic                   tab_zero  [0:63];
	int                     n_rows;
	int                     i;

	execute_stage dut0 (.clk(clk), .rst(rst), .instr(instr), .rs_data(rs_data),
		.rt_data(rt_data), .in_valid(in_valid), .result(result), .zero(zero),
		.out_valid(out_valid));

	execute_checker chk0 (.clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid),
		.result(result), .zero(zero), .exp_result(exp_result), .exp_zero(exp_zero),
		.exp_idx(exp_idx), .pass_count(pass_count), .fail_count(fail_count),
		.done_count(done_count));

	function automatic logic [31:0] make_rtype(input logic [5:0] funct, input logic [4:0] shamt);
		return {`OP_RTYPE, 15'd0, shamt, funct}; // rs/rt/rd numbers unused here
	endfunction

	function automatic logic [31:0] make_itype(input logic [5:0] op, input logic [15:0] imm);
		return {op, 10'd0, imm};
	endfunction

	task automatic add_row(input logic [31:0] ins, input logic [31:0] rs, input logic [31:0] rt,
		input logic [31:0] res, input logic z);
		tab_instr[n_rows] = ins;
		tab_rs[n_rows]    = rs;
		tab_rt[n_rows]    = rt;
		tab_res[n_rows]   = res;
		tab_zero[n_rows]  = z;
		n_rows++;
	endtask

	task automatic load_table;
		n_rows = 0;
		add_row(make_rtype(`FN_ADD, 0), 32'h5, 32'h7, 32'hC, 1'b0);
		add_row(make_rtype(`FN_SUB, 0), 32'h5, 32'h7, 32'hFFFF_FFFE, 1'b0);
		add_row(make_rtype(`FN_AND, 0), 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b0);
		add_row(make_rtype(`FN_OR, 0), 32'hF000_0000, 32'h0000_000F, 32'hF000_000F, 1'b0);
		add_row(make_rtype(`FN_NOR, 0), 32'h0F0F_0F0F, 32'hF0F0_0000, 32'h0000_F0F0, 1'b0);
		add_row(make_rtype(`FN_SLT, 0), 32'hFFFF_FFFB, 32'h3, 32'h1, 1'b0); // -5 < 3
		add_row(make_rtype(`FN_SLL, 4), 32'hFFFF_FFFF, 32'h13, 32'h130, 1'b0); // shifts rt
		add_row(make_rtype(`FN_SRL, 31), 32'h0, 32'h8000_0000, 32'h1, 1'b0);
		add_row(make_itype(`OP_ADDI, 16'hFFFF), 32'hA, 32'h0, 32'h9, 1'b0); // 10 + -1
		add_row(make_itype(`OP_SUBI, 16'hFFFE), 32'hA, 32'h0, 32'hC, 1'b0); // 10 - -2
		add_row(make_itype(`OP_SLTI, 16'hFFF8), 32'h5, 32'h0, 32'h0, 1'b1); // 5 < -8 is false
		add_row(make_itype(`OP_LW, 16'h8004), 32'h1000, 32'h0, 32'hFFFF_9004, 1'b0);
		add_row(make_itype(`OP_ANDI, 16'h8F0F), 32'hFFFF_FFFF, 32'h0, 32'h0000_8F0F, 1'b0);
		add_row(make_itype(`OP_ORI, 16'hABCD), 32'h1234_0000, 32'h0, 32'h1234_ABCD, 1'b0);
		add_row(make_itype(`OP_BEQ, 16'h0), 32'h55, 32'h55, 32'h0, 1'b1);
		add_row(make_itype(`OP_BEQ, 16'h0), 32'h55, 32'h54, 32'h1, 1'b0);
		add_row(make_itype(`OP_BNE, 16'h0), 32'h55, 32'h54, 32'h1, 1'b1); // taken
		add_row(make_itype(`OP_BNE, 16'h0), 32'h55, 32'h55, 32'h0, 1'b0);
		add_row(make_rtype(`FN_MULT, 0), 32'hFFFF_FFFE, 32'h3, 32'h0, 1'b1); // -6 into hi/lo
		add_row(make_rtype(`FN_MFHI, 0), 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0);
		add_row(make_rtype(`FN_MFLO, 0), 32'h0, 32'h0, 32'hFFFF_FFFA, 1'b0);
		add_row(make_rtype(`FN_MUL, 0), 32'h0001_0001, 32'h0001_0001, 32'h0002_0001, 1'b0);
		add_row(make_rtype(`FN_MFHI, 0), 32'h0, 32'h0, 32'h1, 1'b0); // 2^32 carry
		add_row(make_rtype(`FN_DIV, 0), 32'hFFFF_FFF9, 32'h2, 32'h0, 1'b1); // -7 / 2
		add_row(make_rtype(`FN_MFHI, 0), 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0); // rem -1
		add_row(make_rtype(`FN_MFLO, 0), 32'h0, 32'h0, 32'hFFFF_FFFD, 1'b0); // quot -3
		add_row(make_rtype(`FN_DIV, 0), 32'h1234, 32'h0, 32'h0, 1'b1); // divide by zero
		add_row({`OP_J, 26'h18}, 32'h7, 32'h9, 32'h0, 1'b1);   // funct bits look like mult
		add_row({`OP_JAL, 26'h1A}, 32'h5, 32'h3, 32'h0, 1'b1); // funct bits look like div
		add_row(make_rtype(`FN_JR, 0), 32'h7, 32'h9, 32'h0, 1'b1);
		add_row(make_rtype(6'b111111, 0), 32'h7, 32'h9, 32'h0, 1'b1); // unknown funct
		add_row(make_rtype(`FN_MFHI, 0), 32'h0, 32'h0, 32'h1234, 1'b0); // hi kept
		add_row(make_rtype(`FN_MFLO, 0), 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial
	begin
		rst        = 1'b1;
		instr      = '0;
		rs_data    = '0;
		rt_data    = '0;
		in_valid   = 1'b0;
		exp_result = '0;
		exp_zero   = 1'b0;
		exp_idx    = 0;
		load_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (i = 0; i < n_rows; i++)
		begin
			@(posedge clk); // rows go back to back
			instr      <= tab_instr[i];
			rs_data    <= tab_rs[i];
			rt_data    <= tab_rt[i];
			in_valid   <= 1'b1;
			exp_result <= tab_res[i];
			exp_zero   <= tab_zero[i];
			exp_idx    <= i;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		wait (done_count == n_rows);
		repeat (2) @(posedge clk); // room for a stray out_valid
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog sized from the table length plus margin
	initial
	begin
		@(negedge rst);
		#((n_rows + 20) * 8);
		$display("timeout: only %0d of %0d results came back", done_count, n_rows);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+.
mips_pkg.sv
main_control.sv
alu_control.sv
alu.sv
execute_stage.sv
execute_checker.sv
execute_assert.sv
tb_execute_stage.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module tb_execute_stage -o sim_execute_stage

# the simulator may stop on an assertion, the log decides
./obj_dir/sim_execute_stage > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
else
	echo "execute stage run did not pass, see sim.log"
	exit 1
fi
